//--- chirp_weight.f
+incdir+logic
logic/chirp_weight_pkg.sv
logic/chirp_offset_remover.sv
logic/chirp_weight_ram.sv
logic/chirp_weight_mult.sv
logic/chirp_weight_top.sv
dv/chirp_weight_checker.sv
dv/chirp_weight_tb.sv

//--- dv/chirp_weight_tb.sv
`timescale 1ns/1ps
`include "chirp_weight_macros.svh"

module chirp_weight_tb;

  import chirp_weight_pkg::*;

  // stimulus length per phase, in cycles
  localparam int STIM_CYCLES = 4 + 12 + 56 + 72 + 40 + 94 + 10;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

  logic      clk = 1'b0;
  logic      rst_n;
  mul_mode_e i_mode;
  logic      i_valid;
  sample_t   i_sample;
  logic      i_chirp_start;
  sample_t   i_offset;
  logic      i_w_wr_en;
  bin_idx_t  i_w_addr;
  sample_t   i_w_data;
  logic      o_valid;
  sample_t   o_result;

  logic [15:0] lfsr_state;
  int          cycle_cnt = 0;

  // 8 ns period
  always #4 clk = ~clk;

  chirp_weight_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_mode        (i_mode),
    .i_valid       (i_valid),
    .i_sample      (i_sample),
    .i_chirp_start (i_chirp_start),
    .i_offset      (i_offset),
    .i_w_wr_en     (i_w_wr_en),
    .i_w_addr      (i_w_addr),
    .i_w_data      (i_w_data),
    .o_valid       (o_valid),
    .o_result      (o_result)
  );

  chirp_weight_checker u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_mode        (i_mode),
    .i_valid       (i_valid),
    .i_sample      (i_sample),
    .i_chirp_start (i_chirp_start),
    .i_offset      (i_offset),
    .i_w_wr_en     (i_w_wr_en),
    .i_w_addr      (i_w_addr),
    .i_w_data      (i_w_data),
    .i_dut_valid   (o_valid),
    .i_dut_result  (o_result)
  );

  //////////////////////////////////////////////////
  // random source and drive tasks
  //////////////////////////////////////////////////

  // taps 16 14 13 11, maximal length
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one step per bit taken
  task automatic rand_word(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // small signed offset per lane
  task automatic random_offset(output sample_t off);
    logic [31:0] a;
    logic [31:0] b;
    rand_word(8, a);
    rand_word(8, b);
    off = {{8{b[7]}}, b[7:0], {8{a[7]}}, a[7:0]};
  endtask

  task automatic send_sample(input sample_t x, input sample_t off, input logic start);
    @(negedge clk);
    i_valid       = 1'b1;
    i_sample      = x;
    i_offset      = off;
    i_chirp_start = start;
    i_w_wr_en     = 1'b0;
  endtask

  task automatic write_weight(input bin_idx_t addr, input sample_t data);
    @(negedge clk);
    i_valid       = 1'b0;
    i_chirp_start = 1'b0;
    i_w_wr_en     = 1'b1;
    i_w_addr      = addr;
    i_w_data      = data;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      i_valid       = 1'b0;
      i_chirp_start = 1'b0;
      i_w_wr_en     = 1'b0;
    end
  endtask

  task automatic load_random_weights();
    logic [31:0] w;
    for (int b = 0; b < `CW_CHIRP_LEN; b++) begin
      rand_word(32, w);
      write_weight(bin_idx_t'(b), w);
    end
  endtask

  // full scale corners, packed as sample, weight, offset
  function automatic logic [95:0] sat_vector(input int i);
    logic [95:0] v;
    case (i)
      0: v = {32'h8000_8000, 32'h8000_8000, 32'h0000_0000};
      1: v = {32'h7fff_7fff, 32'h8000_8000, 32'h0000_0000};
      2: v = {32'h8000_7fff, 32'h7fff_8000, 32'h0000_0000};
      3: v = {32'h8000_8000, 32'h7fff_7fff, 32'h7fff_7fff};
      4: v = {32'h7fff_7fff, 32'h7fff_8000, 32'h8000_8000};
      5: v = {32'h1234_8000, 32'h8000_7fff, 32'h8000_4000};
      6: v = {32'h4000_c000, 32'h8000_8000, 32'hc000_4000};
      default: v = {32'hffff_0001, 32'h0001_ffff, 32'h0000_0000};
    endcase
    return v;
  endfunction

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] x;
    logic [95:0] vec;
    sample_t     off;
    int          errs;
    lfsr_state    = 16'd74;
    rst_n         = 1'b0;
    i_mode        = MODE_COMPLEX;
    i_valid       = 1'b0;
    i_sample      = '0;
    i_chirp_start = 1'b0;
    i_offset      = '0;
    i_w_wr_en     = 1'b0;
    i_w_addr      = '0;
    i_w_data      = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // weights still cleared from reset
    random_offset(off);
    for (int i = 0; i < 4; i++) begin
      rand_word(32, x);
      send_sample(x, off, i == 0);
    end
    idle(8);

    // complex, two chirps back to back
    load_random_weights();
    for (int i = 0; i < 32; i++) begin
      rand_word(32, x);
      send_sample(x, off, (i % 16) == 0);
    end
    idle(8);

    // real lanes, dense then gapped
    i_mode = MODE_REAL;
    load_random_weights();
    random_offset(off);
    for (int i = 0; i < 16; i++) begin
      rand_word(32, x);
      send_sample(x, off, i == 0);
    end
    for (int i = 0; i < 16; i++) begin
      rand_word(32, x);
      send_sample(x, off, i == 0);
      idle(1);
    end
    idle(8);

    // clamp corners in both modes
    for (int i = 0; i < 8; i++) begin
      vec = sat_vector(i);
      write_weight(bin_idx_t'(i), vec[63:32]);
    end
    for (int m = 0; m < 2; m++) begin
      i_mode = (m == 0) ? MODE_REAL : MODE_COMPLEX;
      for (int i = 0; i < 8; i++) begin
        vec = sat_vector(i);
        send_sample(vec[95:64], vec[31:0], i == 0);
      end
      idle(8);
    end

    // restart mid chirp, wrap, then new weights
    i_mode = MODE_COMPLEX;
    load_random_weights();
    random_offset(off);
    for (int i = 0; i < 30; i++) begin
      rand_word(32, x);
      send_sample(x, off, i == 0 || i == 10);
    end
    idle(8);
    load_random_weights();
    for (int i = 0; i < 16; i++) begin
      rand_word(32, x);
      send_sample(x, off, i == 0);
    end
    idle(8);

    idle(10);
    u_chk.report_counts(errs);
    if (errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

//--- dv/chirp_weight_checker.sv
`timescale 1ns/1ps
`include "chirp_weight_macros.svh"

module chirp_weight_checker (
  input  logic                        clk,
  input  logic                        rst_n,
  input  chirp_weight_pkg::mul_mode_e i_mode,
  input  logic                        i_valid,
  input  chirp_weight_pkg::sample_t   i_sample,
  input  logic                        i_chirp_start,
  input  chirp_weight_pkg::sample_t   i_offset,
  input  logic                        i_w_wr_en,
  input  chirp_weight_pkg::bin_idx_t  i_w_addr,
  input  chirp_weight_pkg::sample_t   i_w_data,
  input  logic                        i_dut_valid,
  input  chirp_weight_pkg::sample_t   i_dut_result
);

  import chirp_weight_pkg::*;

  // producer adds one cycle ahead of the consumer
  localparam int LAT_CPLX = `CW_LAT_COMPLEX + 1;
  localparam int LAT_REAL = `CW_LAT_REAL + 1;

  // weight mirror and bin position
  logic [31:0] shadow [`CW_CHIRP_LEN];
  int          bin_cnt = 0;
  longint      cyc = 0;

  // expected results oldest first with their due cycle
  logic [31:0] exp_q [$];
  longint      due_q [$];

  int n_checked  = 0;
  int value_errs = 0;
  int valid_errs = 0;

  //////////////////////////////////////////////////
  // reference arithmetic
  //////////////////////////////////////////////////

  function automatic logic [15:0] clamp16(input longint v);
    logic [15:0] r;
    if (v > 32767) r = 16'h7fff;
    else if (v < -32768) r = 16'h8000;
    else r = v[15:0];
    return r;
  endfunction

  function automatic logic [31:0] expect_result(input logic [31:0] x, input logic [31:0] off,
                                                input logic [31:0] w, input logic real_mode);
    longint xr;
    longint xi;
    longint wr;
    longint wi;
    longint a;
    longint b;
    longint yr;
    longint yi;
    // offset step per lane with clamp
    a  = $signed(x[15:0]);
    b  = $signed(off[15:0]);
    xr = $signed(clamp16(a - b));
    a  = $signed(x[31:16]);
    b  = $signed(off[31:16]);
    xi = $signed(clamp16(a - b));
    wr = $signed(w[15:0]);
    wi = $signed(w[31:16]);
    if (real_mode) begin
      yr = xr * wr;
      yi = xi * wi;
    end else begin
      yr = xr * wr - xi * wi;
      yi = xr * wi + xi * wr;
    end
    // floor shift and clamp with imag or high lane on top
    return {clamp16(yi >>> 15), clamp16(yr >>> 15)};
  endfunction

  //////////////////////////////////////////////////
  // compare and predict
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    int          cur;
    longint      due;
    logic [31:0] want;
    cyc = cyc + 1;
    // outputs seen before this edge updates them
    if (i_dut_valid) begin
      if (exp_q.size() == 0) begin
        valid_errs++;
        $display("error at %0t: output valid with no result outstanding", $time);
      end else begin
        want = exp_q.pop_front();
        due  = due_q.pop_front();
        n_checked++;
        if (due != cyc) begin
          valid_errs++;
          $display("error at %0t: result came at cycle %0d, due at cycle %0d", $time, cyc, due);
        end else if (i_dut_result !== want) begin
          value_errs++;
          $display("Fail at %0t: expected %h, got %h", $time, want, i_dut_result);
        end
      end
    end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
      valid_errs++;
      $display("error at %0t: output valid missing, result was due at cycle %0d",
               $time, due_q[0]);
      want = exp_q.pop_front();
      due  = due_q.pop_front();
    end
    // inputs driven on the falling edge are stable here
    if (!rst_n) begin
      for (int i = 0; i < `CW_CHIRP_LEN; i++) begin
        shadow[i] = '0;
      end
      bin_cnt = 0;
    end else begin
      if (i_valid) begin
        cur = i_chirp_start ? 0 : bin_cnt;
        exp_q.push_back(expect_result(i_sample, i_offset, shadow[cur], i_mode == MODE_REAL));
        due_q.push_back(cyc + ((i_mode == MODE_REAL) ? LAT_REAL : LAT_CPLX));
        bin_cnt = (cur == `CW_CHIRP_LEN - 1) ? 0 : cur + 1;
      end else if (i_chirp_start) begin
        bin_cnt = 0;
      end
      // store read of this edge still sees the old weight
      if (i_w_wr_en) shadow[i_w_addr] = i_w_data;
    end
  end

  // closing line and the sum of all error kinds
  task report_counts(output int total);
    total = value_errs + valid_errs + exp_q.size();
    $display("summary: %0d results checked, %0d value errors, %0d valid errors, %0d never seen",
             n_checked, value_errs, valid_errs, exp_q.size());
  endtask

endmodule

//--- logic/chirp_weight_top.sv
`timescale 1ns/1ps

module chirp_weight_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  chirp_weight_pkg::mul_mode_e i_mode,
  input  logic                        i_valid,
  input  chirp_weight_pkg::sample_t   i_sample,
  input  logic                        i_chirp_start,
  input  chirp_weight_pkg::sample_t   i_offset,
  input  logic                        i_w_wr_en,
  input  chirp_weight_pkg::bin_idx_t  i_w_addr,
  input  chirp_weight_pkg::sample_t   i_w_data,
  output logic                        o_valid,
  output chirp_weight_pkg::sample_t   o_result
);

  import chirp_weight_pkg::*;

  // producer to consumer
  logic    corr_valid;
  sample_t corr_sample;

  // producer to weight store
  logic     rd_en;
  bin_idx_t rd_addr;

  // weight store to consumer, aligned with corr_sample
  sample_t weight;

  //////////////////////////////////////////////////
  // offset removal and bin count
  //////////////////////////////////////////////////

  chirp_offset_remover u_offset (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (i_valid),
    .i_sample      (i_sample),
    .i_chirp_start (i_chirp_start),
    .i_offset      (i_offset),
    .o_valid       (corr_valid),
    .o_sample      (corr_sample),
    .o_rd_en       (rd_en),
    .o_rd_addr     (rd_addr)
  );

  // per-bin weights, host loaded
  chirp_weight_ram u_ram (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_wr_en   (i_w_wr_en),
    .i_wr_addr (i_w_addr),
    .i_wr_data (i_w_data),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (weight)
  );

  // weighting product, 4 or 2 cycles
  chirp_weight_mult u_mult (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_mode  (i_mode),
    .i_valid (corr_valid),
    .i_x     (corr_sample),
    .i_w     (weight),
    .o_valid (o_valid),
    .o_y     (o_result)
  );

endmodule

//--- logic/chirp_weight_mult.sv
`timescale 1ns/1ps
`include "chirp_weight_macros.svh"

module chirp_weight_mult (
  input  logic                        clk,
  input  logic                        rst_n,
  input  chirp_weight_pkg::mul_mode_e i_mode,
  input  logic                        i_valid,
  input  chirp_weight_pkg::sample_t   i_x,
  input  chirp_weight_pkg::sample_t   i_w,
  output logic                        o_valid,
  output chirp_weight_pkg::sample_t   o_y
);

  import chirp_weight_pkg::*;

  // operand lanes
  lane_t xr;
  lane_t xi;
  lane_t wr;
  lane_t wi;

  // stage 1, gauss pre-adds and delayed operands
  logic signed [`CW_LANE_W:0] s1_xpx;
  logic signed [`CW_LANE_W:0] s1_wmw;
  logic signed [`CW_LANE_W:0] s1_wpw;
  lane_t s1_xr;
  lane_t s1_xi;
  lane_t s1_wr;

  // stage 2, three products
  wide_t s2_p1;
  wide_t s2_p2;
  wide_t s2_p3;

  // stage 3, real and imag sums
  wide_t s3_re;
  wide_t s3_im;

  // real path, one product per lane
  wide_t r1_hi;
  wide_t r1_lo;

  // results ahead of the output register
  sample_t cplx_y;
  sample_t real_y;

  // valid delay lines, one per mode
  logic [`CW_LAT_COMPLEX-1:0] vld_cplx;
  logic [`CW_LAT_REAL-1:0]    vld_real;

  assign xr = i_x[`CW_LANE_W-1:0];
  assign xi = i_x[2*`CW_LANE_W-1:`CW_LANE_W];
  assign wr = i_w[`CW_LANE_W-1:0];
  assign wi = i_w[2*`CW_LANE_W-1:`CW_LANE_W];

  //////////////////////////////////////////////////
  // complex path, three multipliers
  //////////////////////////////////////////////////

  // re = wr(xr+xi) - xi(wr+wi)
  // im = wr(xr+xi) + xr(wi-wr)
  always_ff @(posedge clk) begin
    s1_xpx <= xr + xi;
    s1_wmw <= wi - wr;
    s1_wpw <= wr + wi;
    s1_xr  <= xr;
    s1_xi  <= xi;
    s1_wr  <= wr;
  end

  // 16 x 17 products, sign extended into 34 bits
  always_ff @(posedge clk) begin
    s2_p1 <= s1_wr * s1_xpx;
    s2_p2 <= s1_xr * s1_wmw;
    s2_p3 <= s1_xi * s1_wpw;
  end

  // shared term p1 feeds both parts
  always_ff @(posedge clk) begin
    s3_re <= s2_p1 - s2_p3;
    s3_im <= s2_p1 + s2_p2;
  end

  // floor shift then clamp, imag on top
  assign cplx_y = {sat_lane(s3_im >>> `CW_FRAC_BITS),
                   sat_lane(s3_re >>> `CW_FRAC_BITS)};

  //////////////////////////////////////////////////
  // real path, two independent lanes
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    r1_hi <= xi * wi;
    r1_lo <= xr * wr;
  end

  assign real_y = {sat_lane(r1_hi >>> `CW_FRAC_BITS),
                   sat_lane(r1_lo >>> `CW_FRAC_BITS)};

  //////////////////////////////////////////////////
  // output select
  //////////////////////////////////////////////////

  // last stage of either path lands here
  always_ff @(posedge clk) begin
    if (i_mode == MODE_REAL) o_y <= real_y;
    else o_y <= cplx_y;
  end

  // valid tracks the selected path depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_cplx <= '0;
      vld_real <= '0;
    end else begin
      vld_cplx <= {vld_cplx[`CW_LAT_COMPLEX-2:0], i_valid};
      vld_real <= {vld_real[`CW_LAT_REAL-2:0], i_valid};
    end
  end

  // mode is stable while samples are in flight
  assign o_valid = (i_mode == MODE_REAL) ? vld_real[`CW_LAT_REAL-1]
                                         : vld_cplx[`CW_LAT_COMPLEX-1];

endmodule

//--- logic/chirp_weight_ram.sv
`timescale 1ns/1ps
`include "chirp_weight_macros.svh"

module chirp_weight_ram (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        i_wr_en,
  input  chirp_weight_pkg::bin_idx_t  i_wr_addr,
  input  chirp_weight_pkg::sample_t   i_wr_data,
  input  logic                        i_rd_en,
  input  chirp_weight_pkg::bin_idx_t  i_rd_addr,
  output chirp_weight_pkg::sample_t   o_rd_data
);

  import chirp_weight_pkg::*;

  // one packed weight per bin
  sample_t mem [`CW_CHIRP_LEN];

  //////////////////////////////////////////////////
  // host write port
  //////////////////////////////////////////////////

  // all weights start at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CW_CHIRP_LEN; i++) begin
        mem[i] <= '0;
      end
    end else if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  //////////////////////////////////////////////////
  // registered read
  //////////////////////////////////////////////////

  // holds last read when enable is low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

//--- logic/chirp_offset_remover.sv
`timescale 1ns/1ps
`include "chirp_weight_macros.svh"

module chirp_offset_remover (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        i_valid,
  input  chirp_weight_pkg::sample_t   i_sample,
  input  logic                        i_chirp_start,
  input  chirp_weight_pkg::sample_t   i_offset,
  output logic                        o_valid,
  output chirp_weight_pkg::sample_t   o_sample,
  output logic                        o_rd_en,
  output chirp_weight_pkg::bin_idx_t  o_rd_addr
);

  import chirp_weight_pkg::*;

  // split lanes of sample and offset
  lane_t x_re;
  lane_t x_im;
  lane_t off_re;
  lane_t off_im;

  // one extra bit, difference cannot wrap
  logic signed [`CW_LANE_W:0] diff_re;
  logic signed [`CW_LANE_W:0] diff_im;

  // bin counter and the bin used this cycle
  bin_idx_t bin_cnt;
  bin_idx_t cur_bin;

  //////////////////////////////////////////////////
  // offset removal
  //////////////////////////////////////////////////

  assign x_re   = i_sample[`CW_LANE_W-1:0];
  assign x_im   = i_sample[2*`CW_LANE_W-1:`CW_LANE_W];
  assign off_re = i_offset[`CW_LANE_W-1:0];
  assign off_im = i_offset[2*`CW_LANE_W-1:`CW_LANE_W];

  assign diff_re = x_re - off_re;
  assign diff_im = x_im - off_im;

  // corrected sample, held between strobes
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_sample <= {sat_lane(diff_im), sat_lane(diff_re)};
    end
  end

  // valid follows the input by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  //////////////////////////////////////////////////
  // bin index and weight read
  //////////////////////////////////////////////////

  // chirp start forces bin 0 for this sample
  assign cur_bin = i_chirp_start ? '0 : bin_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bin_cnt <= '0;
    end else if (i_valid) begin
      // wrap after the last bin of a chirp
      if (cur_bin == bin_idx_t'(`CW_CHIRP_LEN - 1)) bin_cnt <= '0;
      else bin_cnt <= cur_bin + 1'b1;
    end else if (i_chirp_start) begin
      bin_cnt <= '0;
    end
  end

  // read issued in the strobe cycle, data lands with o_sample
  assign o_rd_en   = i_valid;
  assign o_rd_addr = cur_bin;

endmodule

//--- logic/chirp_weight_pkg.sv
`include "chirp_weight_macros.svh"

package chirp_weight_pkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  // packed pair, upper half is imag or high lane
  typedef logic [`CW_SAMPLE_W-1:0] sample_t;

  // one signed lane
  typedef logic signed [`CW_LANE_W-1:0] lane_t;

  // bin position inside a chirp
  typedef logic [`CW_BIN_W-1:0] bin_idx_t;

  // product / sum accumulator, 34 bits
  typedef logic signed [2*`CW_LANE_W+1:0] wide_t;

  // arithmetic mode, 1 selects the real lane path
  typedef enum logic {
    MODE_COMPLEX = 1'b0,
    MODE_REAL    = 1'b1
  } mul_mode_e;

  // lane limits
  localparam lane_t LANE_MAX = 16'sh7fff;
  localparam lane_t LANE_MIN = 16'sh8000;

  //////////////////////////////////////////////////
  // saturation
  //////////////////////////////////////////////////

  // clamp a wide signed value into one lane
  function automatic lane_t sat_lane(input wide_t v);
    lane_t res;
    if (v > LANE_MAX) res = LANE_MAX;
    else if (v < LANE_MIN) res = LANE_MIN;
    else res = lane_t'(v);
    return res;
  endfunction

endpackage

//--- logic/chirp_weight_macros.svh
`ifndef CHIRP_WEIGHT_MACROS_SVH
`define CHIRP_WEIGHT_MACROS_SVH

//////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////

// packed sample or weight, imag / high lane on top
`define CW_SAMPLE_W    32
// one lane of a packed pair
`define CW_LANE_W      16

// chirp geometry, also weight store depth
`define CW_CHIRP_LEN   16
`define CW_BIN_W       4

// q1.15 fixed point
`define CW_FRAC_BITS   15

// consumer pipeline depth per mode
`define CW_LAT_COMPLEX 4
`define CW_LAT_REAL    2

`endif
